// File: sdCmd.f
source/sdCmdPkg.sv
source/crc7.sv
source/cmdSerializer.sv
source/respDeserializer.sv
source/cmdController.sv
source/sdCmdPort.sv
testbench/tbClock.sv
testbench/sdCmdChecker.sv
testbench/sdCmdTb.sv

// File: runSim.sh
#!/bin/sh
# compile the SD command port testbench with Verilator and run it
# a run fails on a bad build, a bad exit status or the fail message in the log

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing --timescale 1ns/1ns \
    --top-module sdCmdTb -Mdir "$buildDir" -o sdCmdSim \
    -f sdCmd.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$buildDir/sdCmdSim" > "$logFile" 2>&1
runStatus=$?
cat "$logFile"
if [ $runStatus -ne 0 ]; then
    echo "simulation exited with status $runStatus"
    exit 1
fi

if grep -q "Errors found" "$logFile"; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
exit 0

// File: testbench/sdCmdTb.sv
`timescale 1ns/1ns
`default_nettype none

// random commands from the host side, a card model answering on cmdIn
module sdCmdTb;

    logic               clk;
    logic               rst;
    logic               req;
    logic [5:0]         cmdIndex;
    logic [31:0]        cmdArg;
    logic               expectResp;
    logic               cmdIn;
    logic               ack;
    sdCmdPkg::cmdStatus status;
    logic [31:0]        respArg;
    logic               cmdOut;
    logic               cmdOe;
    int                 valueErrors;
    int                 protocolErrors;
    int                 commandsChecked;
    integer             seed;
    int                 waitLimit;
    int                 cmdNum;
    logic               hung;
    logic               lostCommands;
    // token as the card heard it on cmdOut
    logic [47:0]        heardToken;

    tbClock clkGen (
        .clk (clk),
        .rst (rst)
    );

    sdCmdPort DUT (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .ack        (ack),
        .cmdIndex   (cmdIndex),
        .cmdArg     (cmdArg),
        .expectResp (expectResp),
        .status     (status),
        .respArg    (respArg),
        .cmdOut     (cmdOut),
        .cmdOe      (cmdOe),
        .cmdIn      (cmdIn)
    );

    sdCmdChecker watcher (
        .clk             (clk),
        .rst             (rst),
        .req             (req),
        .ack             (ack),
        .cmdIndex        (cmdIndex),
        .cmdArg          (cmdArg),
        .expectResp      (expectResp),
        .status          (status),
        .respArg         (respArg),
        .cmdOut          (cmdOut),
        .cmdOe           (cmdOe),
        .cmdIn           (cmdIn),
        .valueErrors     (valueErrors),
        .protocolErrors  (protocolErrors),
        .commandsChecked (commandsChecked)
    );

    // card side CRC7 over the 40 head bits of a response
    function automatic logic [6:0] responseCrc(input logic [39:0] head);
        logic [6:0] c;
        logic       fb;
        c = 7'd0;
        for (int i = 39; i >= 0; i--) begin
            fb = head[i] ^ c[6];
            c = {c[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
        end
        return c;
    endfunction

    task automatic awaitAck(input logic level);
        int waited;
        waited = 0;
        if (!hung) begin
            do begin
                @(negedge clk);
                waited++;
            end while (ack !== level && waited < waitLimit);
            if (ack !== level) begin
                $display("timeout: ack did not go to %0d within %0d cycles", level, waitLimit);
                hung = 1'b1;
            end
        end
    endtask

    // card listens while cmdOe is high, returns one cycle after the end bit
    task automatic listenCommand();
        int waited;
        waited     = 0;
        heardToken = 48'd0;
        if (!hung) begin
            do begin
                @(negedge clk);
                waited++;
            end while (!cmdOe && waited < waitLimit);
            if (!cmdOe) begin
                $display("timeout: no command token appeared on cmdOut");
                hung = 1'b1;
            end
        end
        if (!hung) begin
            waited = 0;
            while (cmdOe && waited < waitLimit) begin
                heardToken = {heardToken[46:0], cmdOut};
                @(negedge clk);
                waited++;
            end
            if (cmdOe) begin
                $display("timeout: cmdOe never went low again");
                hung = 1'b1;
            end
        end
    endtask

    // start bit lands delay cycles after the command end bit
    task automatic sendResponse(input int delay, input logic [47:0] token);
        if (!hung) begin
            repeat (delay - 2) @(posedge clk);
            for (int i = 47; i >= 0; i--) begin
                @(posedge clk);
                cmdIn <= token[i];
            end
            @(posedge clk);
            cmdIn <= 1'b1;
        end
    endtask

    task automatic runCommand();
        logic [31:0] rnd;
        logic        wantAnswer;
        int          mode;
        int          delay;
        int          hold;
        logic [5:0]  echoIndex;
        logic        transmit;
        logic        endBit;
        logic [6:0]  crc;
        logic [31:0] cardStatus;
        @(posedge clk);
        rnd = $random(seed);
        cmdIndex <= rnd[5:0];
        rnd = $random(seed);
        cmdArg <= rnd;
        rnd = $random(seed);
        // mostly commands with a response
        wantAnswer = (rnd[2:0] != 3'd0);
        expectResp <= wantAnswer;
        req <= 1'b1;
        listenCommand();
        // 0..2 clean, 3 crc, 4 trans bit, 5 end bit, 6 index, 7 silent card
        mode       = int'($unsigned($random(seed)) % 8);
        delay      = 2 + int'($unsigned($random(seed)) % 79);
        cardStatus = $random(seed);
        rnd        = $random(seed);
        echoIndex  = heardToken[45:40];
        transmit   = (mode == 4);
        endBit     = (mode != 5);
        if (mode == 6) begin
            echoIndex = echoIndex ^ (rnd[5:0] | 6'd1);
        end
        crc = responseCrc({1'b0, transmit, echoIndex, cardStatus});
        if (mode == 3) begin
            crc = crc ^ (rnd[14:8] | 7'd1);
        end
        if (wantAnswer && mode != 7) begin
            sendResponse(delay, {1'b0, transmit, echoIndex, cardStatus, crc, endBit});
        end
        awaitAck(1'b1);
        // hold req a while under ack
        hold = int'($unsigned($random(seed)) % 6);
        if (!hung) begin
            repeat (hold + 1) @(posedge clk);
            req <= 1'b0;
        end
        awaitAck(1'b0);
    endtask

    initial begin
        int waited;
        seed       = 32'hfb24b9d1;
        waitLimit  = 500;
        hung       = 1'b0;
        req        = 1'b0;
        cmdIndex   = 6'd0;
        cmdArg     = 32'd0;
        expectResp = 1'b0;
        cmdIn      = 1'b1;
        waited     = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (rst && waited < waitLimit);
        if (rst) begin
            $display("timeout: reset was never released");
            hung = 1'b1;
        end
        for (cmdNum = 0; cmdNum < 80 && !hung; cmdNum++) begin
            runCommand();
        end
        repeat (4) @(posedge clk);
        lostCommands = !hung && (commandsChecked != cmdNum);
        if (lostCommands) begin
            $display("only %0d of %0d commands reached a checked ack", commandsChecked, cmdNum);
        end
        $display("commands checked %0d, value errors %0d, protocol errors %0d, hung %0d",
                 commandsChecked, valueErrors, protocolErrors, hung);
        if (hung || lostCommands || valueErrors != 0 || protocolErrors != 0) begin
            $display("Errors found");
        end else begin
            $display("No errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/sdCmdChecker.sv
`timescale 1ns/1ns
`default_nettype none

// watches both cmd line directions and the host handshake
// expected results come from its own token decode and CRC7 model
module sdCmdChecker (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     req,
    input  wire                     ack,
    input  wire [5:0]               cmdIndex,
    input  wire [31:0]              cmdArg,
    input  wire                     expectResp,
    input  wire sdCmdPkg::cmdStatus status,
    input  wire [31:0]              respArg,
    input  wire                     cmdOut,
    input  wire                     cmdOe,
    input  wire                     cmdIn,
    output int                      valueErrors,
    output int                      protocolErrors,
    output int                      commandsChecked
);

    logic               reqPrev;
    logic               ackPrev;
    logic               oePrev;
    // command captured when req rises
    logic [5:0]         sentIndex;
    logic [31:0]        sentArg;
    logic               sentResp;
    logic               cmdPending;
    // outgoing token, first bit ends up in bit 47
    logic [47:0]        txBits;
    int                 txCount;
    // incoming side
    logic               inWindow;
    logic               inFrame;
    int                 sinceEnd;
    logic [47:0]        rxBits;
    int                 rxCount;
    // result the DUT should hand back
    logic               expValid;
    sdCmdPkg::cmdStatus expStatus;
    logic [31:0]        expRespArg;
    // samples from the known result to the ack rise
    int                 expLatency;
    int                 expAge;
    sdCmdPkg::cmdStatus heldStatus;
    logic [31:0]        heldArg;

    // CRC7 over 40 bits, MSB first, poly 0x09
    function automatic logic [6:0] crcOver40(input logic [39:0] bits);
        logic [6:0] c;
        logic       fb;
        c = 7'd0;
        for (int i = 39; i >= 0; i--) begin
            fb = bits[i] ^ c[6];
            c = {c[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
        end
        return c;
    endfunction

    task automatic mismatch(input string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        valueErrors++;
    endtask

    task automatic protocolFault(input string msg);
        $display("protocol error at %0t: %s", $time, msg);
        protocolErrors++;
    endtask

    task automatic expectResult(input sdCmdPkg::cmdStatus st, input logic [31:0] arg,
                                input int latency);
        expStatus  = st;
        expRespArg = arg;
        expLatency = latency;
        expAge     = 0;
        expValid   = 1'b1;
    endtask

    // called on the sample after the end bit, cycle 1 of the window
    task automatic checkToken();
        logic [6:0] crcModel;
        crcModel = crcOver40(txBits[47:8]);
        if (!cmdPending) begin
            protocolFault("command token on cmdOut without a pending request");
        end
        if (txCount != sdCmdPkg::frameBits) begin
            protocolFault($sformatf("cmdOe was high for %0d cycles", txCount));
        end else begin
            if (txBits[47:46] !== 2'b01) begin
                mismatch($sformatf("start and transmission bits are %b", txBits[47:46]));
            end
            if (txBits[45:40] !== sentIndex) begin
                mismatch($sformatf("index %0d sent, host gave %0d", txBits[45:40], sentIndex));
            end
            if (txBits[39:8] !== sentArg) begin
                mismatch($sformatf("argument %h sent, host gave %h", txBits[39:8], sentArg));
            end
            if (txBits[7:1] !== crcModel) begin
                mismatch($sformatf("command CRC %h, model %h", txBits[7:1], crcModel));
            end
            if (txBits[0] !== 1'b1) begin
                mismatch("command end bit is 0");
            end
        end
        txCount    = 0;
        cmdPending = 1'b0;
        if (sentResp) begin
            inWindow = 1'b1;
            sinceEnd = 1;
        end else begin
            // ack two cycles after the end bit, no response wait
            expectResult(sdCmdPkg::stOk, 32'd0, 1);
        end
    endtask

    // CRC first, then framing and the index echo
    // rxDone follows the last bit, ack two cycles after that
    task automatic decodeResponse();
        if (rxBits[7:1] != crcOver40(rxBits[47:8])) begin
            expectResult(sdCmdPkg::stCrcError, rxBits[39:8], 3);
        end else if (rxBits[46] || !rxBits[0] || rxBits[45:40] != sentIndex) begin
            expectResult(sdCmdPkg::stFrameError, rxBits[39:8], 3);
        end else begin
            expectResult(sdCmdPkg::stOk, rxBits[39:8], 3);
        end
    endtask

    task automatic watchResponse();
        if (inFrame) begin
            rxBits = {rxBits[46:0], cmdIn};
            rxCount++;
            if (rxCount == sdCmdPkg::frameBits) begin
                inFrame = 1'b0;
                decodeResponse();
            end
        end else if (inWindow) begin
            if (cmdIn === 1'b0) begin
                // start bit, counts as the first frame bit
                inWindow = 1'b0;
                inFrame  = 1'b1;
                rxBits   = 48'd0;
                rxCount  = 1;
            end else if (sinceEnd == sdCmdPkg::respWindow) begin
                inWindow = 1'b0;
                // ack two cycles after the last window cycle
                expectResult(sdCmdPkg::stTimeout, 32'd0, 2);
            end else begin
                sinceEnd++;
            end
        end
    endtask

    task automatic checkHandshake();
        if (ack && !ackPrev) begin
            if (!req) begin
                protocolFault("ack rose while req was low");
            end
            if (!expValid) begin
                protocolFault("ack rose before the command had finished on the line");
            end else begin
                if (expAge != expLatency) begin
                    protocolFault($sformatf("ack rose %0d cycles after the result, expected %0d",
                                            expAge, expLatency));
                end
                if (status !== expStatus) begin
                    mismatch($sformatf("status %s, expected %s",
                                       status.name(), expStatus.name()));
                end
                if (respArg !== expRespArg) begin
                    mismatch($sformatf("respArg %h, expected %h", respArg, expRespArg));
                end
            end
            heldStatus = status;
            heldArg    = respArg;
            expValid   = 1'b0;
            commandsChecked++;
        end else if (ack && req) begin
            // back-pressure, result frozen
            if (status !== heldStatus || respArg !== heldArg) begin
                mismatch("result changed while ack and req were high");
            end
        end
        if (!ack && ackPrev && req) begin
            protocolFault("ack fell while req was still high");
        end
    endtask

    always @(negedge clk) begin
        if (rst) begin
            reqPrev         = 1'b0;
            ackPrev         = 1'b0;
            oePrev          = 1'b0;
            cmdPending      = 1'b0;
            txCount         = 0;
            inWindow        = 1'b0;
            inFrame         = 1'b0;
            expValid        = 1'b0;
            expAge          = 0;
            valueErrors     = 0;
            protocolErrors  = 0;
            commandsChecked = 0;
        end else begin
            if (expValid) begin
                expAge++;
            end
            if (req && !reqPrev) begin
                sentIndex  = cmdIndex;
                sentArg    = cmdArg;
                sentResp   = expectResp;
                cmdPending = 1'b1;
                expValid   = 1'b0;
            end
            if (!cmdOe && cmdOut !== 1'b1) begin
                mismatch("cmdOut not high while cmdOe is low");
            end
            if (cmdOe && !oePrev && ack) begin
                protocolFault("new token started while ack was high");
            end
            if (cmdOe) begin
                txBits = {txBits[46:0], cmdOut};
                txCount++;
            end else if (oePrev) begin
                checkToken();
            end
            watchResponse();
            checkHandshake();
            reqPrev = req;
            ackPrev = ack;
            oePrev  = cmdOe;
        end
    end

endmodule

`default_nettype wire

// File: testbench/tbClock.sv
`timescale 1ns/1ns
`default_nettype none

// 100 ns clock, reset held over the first two rising edges
module tbClock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

// File: source/sdCmdPort.sv
`timescale 1ns/1ns
`default_nettype none

// SD command line host port
// host handshake on one side, bit-serial cmd line on the other
module sdCmdPort (
    input  wire                clk,
    input  wire                rst,
    input  wire                req,
    output logic               ack,
    input  wire [5:0]          cmdIndex,
    input  wire [31:0]         cmdArg,
    input  wire                expectResp,
    output sdCmdPkg::cmdStatus status,
    output logic [31:0]        respArg,
    output logic               cmdOut,
    output logic               cmdOe,
    input  wire                cmdIn
);

    // controller to serializer
    logic        txStart;
    logic        txDone;

    // controller to deserializer
    logic        rxEnable;
    logic        rxStartSeen;
    logic        rxDone;
    logic        crcOk;
    logic        endOk;
    logic        transBit;
    logic [5:0]  rxIndex;
    logic [31:0] rxArg;

    cmdController ctrl (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .ack         (ack),
        .cmdIndex    (cmdIndex),
        .expectResp  (expectResp),
        .status      (status),
        .respArg     (respArg),
        .txStart     (txStart),
        .txDone      (txDone),
        .rxEnable    (rxEnable),
        .rxStartSeen (rxStartSeen),
        .rxDone      (rxDone),
        .crcOk       (crcOk),
        .endOk       (endOk),
        .transBit    (transBit),
        .rxIndex     (rxIndex),
        .rxArg       (rxArg)
    );

    // argument goes straight from the host, held stable under req
    cmdSerializer tx (
        .clk      (clk),
        .rst      (rst),
        .txStart  (txStart),
        .cmdIndex (cmdIndex),
        .cmdArg   (cmdArg),
        .cmdOut   (cmdOut),
        .cmdOe    (cmdOe),
        .txDone   (txDone)
    );

    respDeserializer rx (
        .clk         (clk),
        .rst         (rst),
        .rxEnable    (rxEnable),
        .cmdIn       (cmdIn),
        .rxStartSeen (rxStartSeen),
        .rxDone      (rxDone),
        .crcOk       (crcOk),
        .endOk       (endOk),
        .transBit    (transBit),
        .rxIndex     (rxIndex),
        .rxArg       (rxArg)
    );

endmodule

`default_nettype wire

// File: source/cmdController.sv
`timescale 1ns/1ns
`default_nettype none

// host handshake and command sequencing
// ack goes high one cycle after the FSM reaches done
module cmdController (
    input  wire                clk,
    input  wire                rst,
    input  wire                req,
    output logic               ack,
    input  wire [5:0]          cmdIndex,
    input  wire                expectResp,
    output sdCmdPkg::cmdStatus status,
    output logic [31:0]        respArg,
    output logic               txStart,
    input  wire                txDone,
    output logic               rxEnable,
    input  wire                rxStartSeen,
    input  wire                rxDone,
    input  wire                crcOk,
    input  wire                endOk,
    input  wire                transBit,
    input  wire [5:0]          rxIndex,
    input  wire [31:0]         rxArg
);

    sdCmdPkg::ctrlState state;
    sdCmdPkg::cmdStatus rxStatus;
    logic [5:0]         sentIndex;
    logic               wantResp;
    logic [6:0]         windowTimer;
    logic               windowOver;

    // cycles since the end bit, start bit accepted up to respWindow
    assign windowOver = (windowTimer == 7'(sdCmdPkg::respWindow));

    // crc first, then framing and index echo
    always_comb begin
        if (!crcOk) begin
            rxStatus = sdCmdPkg::stCrcError;
        end else if (!endOk || transBit || (rxIndex != sentIndex)) begin
            rxStatus = sdCmdPkg::stFrameError;
        end else begin
            rxStatus = sdCmdPkg::stOk;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= sdCmdPkg::idle;
            ack         <= 1'b0;
            txStart     <= 1'b0;
            rxEnable    <= 1'b0;
            status      <= sdCmdPkg::stOk;
            wantResp    <= 1'b0;
            windowTimer <= '0;
        end else begin
            // one-cycle pulse
            txStart <= 1'b0;
            case (state)
                sdCmdPkg::idle: begin
                    if (req) begin
                        txStart  <= 1'b1;
                        wantResp <= expectResp;
                        state    <= sdCmdPkg::sending;
                    end
                end
                sdCmdPkg::sending: begin
                    if (txDone && wantResp) begin
                        // arm receiver, first window cycle counts as 1
                        rxEnable    <= 1'b1;
                        windowTimer <= 7'd1;
                        state       <= sdCmdPkg::waiting;
                    end else if (txDone) begin
                        status <= sdCmdPkg::stOk;
                        state  <= sdCmdPkg::done;
                    end
                end
                sdCmdPkg::waiting: begin
                    if (rxStartSeen) begin
                        state <= sdCmdPkg::receiving;
                    end else if (windowOver) begin
                        rxEnable <= 1'b0;
                        status   <= sdCmdPkg::stTimeout;
                        state    <= sdCmdPkg::done;
                    end else begin
                        windowTimer <= windowTimer + 7'd1;
                    end
                end
                sdCmdPkg::receiving: begin
                    if (rxDone) begin
                        rxEnable <= 1'b0;
                        status   <= rxStatus;
                        state    <= sdCmdPkg::done;
                    end
                end
                sdCmdPkg::done: begin
                    // result held until the host lets go of req
                    if (!ack) begin
                        ack <= 1'b1;
                    end else if (!req) begin
                        ack   <= 1'b0;
                        state <= sdCmdPkg::idle;
                    end
                end
                default: begin
                    state <= sdCmdPkg::idle;
                end
            endcase
        end
    end

    // index kept for the echo check
    always_ff @(posedge clk) begin
        if (state == sdCmdPkg::idle && req) begin
            sentIndex <= cmdIndex;
        end
    end

    // card status only when a frame came back
    always_ff @(posedge clk) begin
        if (state == sdCmdPkg::sending && txDone && !wantResp) begin
            respArg <= '0;
        end else if (state == sdCmdPkg::waiting && !rxStartSeen && windowOver) begin
            respArg <= '0;
        end else if (state == sdCmdPkg::receiving && rxDone) begin
            respArg <= rxArg;
        end
    end

endmodule

`default_nettype wire

// File: source/respDeserializer.sv
`timescale 1ns/1ns
`default_nettype none

// captures a 48-bit short response from the command line
// start bit at count 0, bits 1..47 land in the shift register
module respDeserializer (
    input  wire        clk,
    input  wire        rst,
    input  wire        rxEnable,
    input  wire        cmdIn,
    output logic       rxStartSeen,
    output logic       rxDone,
    output logic       crcOk,
    output logic       endOk,
    output logic       transBit,
    output logic [5:0] rxIndex,
    output logic [31:0] rxArg
);

    logic        busy;
    logic [5:0]  bitCnt;
    logic [46:0] shiftIn;
    logic        lastBit;
    logic        crcFeed;
    logic [6:0]  crcRem;

    // a low line while armed and idle is a start bit
    // the rxDone cycle is skipped so the tail of a frame cannot retrigger
    assign rxStartSeen = rxEnable && !busy && !rxDone && !cmdIn;

    assign lastBit = busy && (bitCnt == 6'(sdCmdPkg::frameBits - 1));

    // transmission bit through the received CRC, end bit excluded
    assign crcFeed = busy && (bitCnt < 6'(sdCmdPkg::frameBits - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            busy   <= 1'b0;
            bitCnt <= '0;
            rxDone <= 1'b0;
            crcOk  <= 1'b0;
        end else begin
            rxDone <= 1'b0;
            if (rxStartSeen) begin
                busy   <= 1'b1;
                bitCnt <= 6'd1;
            end else if (busy) begin
                bitCnt <= bitCnt + 6'd1;
                if (lastBit) begin
                    busy   <= 1'b0;
                    rxDone <= 1'b1;
                    // register already holds bits 1..46 at this point
                    crcOk  <= (crcRem == '0);
                end
            end
        end
    end

    // payload, stable from rxDone until the next start bit
    always_ff @(posedge clk) begin
        if (busy) begin
            shiftIn <= {shiftIn[45:0], cmdIn};
        end
    end

    // field positions after 47 shifts
    assign transBit = shiftIn[46];
    assign rxIndex  = shiftIn[45:40];
    assign rxArg    = shiftIn[39:8];
    // shiftIn[7:1] is the received CRC, only checked through the remainder
    assign endOk    = shiftIn[0];

    // zero remainder over bits 1..46 means a good frame
    crc7 rxCrc (
        .clk       (clk),
        .rst       (rst),
        .clear     (rxStartSeen),
        .en        (crcFeed),
        .din       (cmdIn),
        .dout      (),
        .remainder (crcRem)
    );

endmodule

`default_nettype wire

// File: source/cmdSerializer.sv
`timescale 1ns/1ns
`default_nettype none

// frames index and argument into the 48-bit command token
// bits 0..39 from the head register, 40..46 from the CRC, 47 the end bit
module cmdSerializer (
    input  wire        clk,
    input  wire        rst,
    input  wire        txStart,
    input  wire [5:0]  cmdIndex,
    input  wire [31:0] cmdArg,
    output logic       cmdOut,
    output logic       cmdOe,
    output logic       txDone
);

    logic        active;
    logic [5:0]  bitCnt;
    logic [39:0] head;
    logic        inHead;
    logic        inCrc;
    logic        loadHead;
    logic        crcOut;

    // new token only when the line is free
    assign loadHead = txStart && !active;

    // phases of the token by bit position
    assign inHead = bitCnt < 6'(sdCmdPkg::frameBits - sdCmdPkg::crcBits - 1);
    assign inCrc  = !inHead && (bitCnt < 6'(sdCmdPkg::frameBits - 1));

    // end bit cycle
    assign txDone = active && (bitCnt == 6'(sdCmdPkg::frameBits - 1));

    assign cmdOe = active;

    always_comb begin
        if (!active) begin
            // line idles high
            cmdOut = 1'b1;
        end else if (inHead) begin
            cmdOut = head[39];
        end else if (inCrc) begin
            cmdOut = crcOut;
        end else begin
            // end bit
            cmdOut = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
            bitCnt <= '0;
        end else if (loadHead) begin
            active <= 1'b1;
            bitCnt <= '0;
        end else if (active) begin
            bitCnt <= bitCnt + 6'd1;
            if (txDone) begin
                active <= 1'b0;
            end
        end
    end

    // start bit 0, transmission bit 1, index, argument
    always_ff @(posedge clk) begin
        if (loadHead) begin
            head <= {1'b0, 1'b1, cmdIndex, cmdArg};
        end else if (active && inHead) begin
            head <= {head[38:0], 1'b0};
        end
    end

    // fed over the head bits, then shifted out with en low
    crc7 txCrc (
        .clk       (clk),
        .rst       (rst),
        .clear     (loadHead),
        .en        (active && inHead),
        .din       (head[39]),
        .dout      (crcOut),
        .remainder ()
    );

endmodule

`default_nettype wire

// File: source/crc7.sv
`timescale 1ns/1ns
`default_nettype none

// serial CRC7, polynomial x^7 + x^3 + 1
// with en low the register shifts the remainder out on dout, MSB first
module crc7 (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         clear,
    input  wire                         en,
    input  wire                         din,
    output logic                        dout,
    output logic [sdCmdPkg::crcBits-1:0] remainder
);

    logic [sdCmdPkg::crcBits-1:0] crcReg;
    logic                         feedback;

    // feedback only while a data bit is being absorbed
    assign feedback = en ? (din ^ crcReg[6]) : 1'b0;

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            crcReg <= '0;
        end else begin
            // taps at bit 0 and bit 3, the rest is a plain shift
            crcReg <= {crcReg[5:3], crcReg[2] ^ feedback, crcReg[1:0], feedback};
        end
    end

    // top bit is the next serial output
    assign dout = crcReg[6];

    // whole register for zero checks on received frames
    assign remainder = crcReg;

endmodule

`default_nettype wire

// File: source/sdCmdPkg.sv
`default_nettype none

package sdCmdPkg;

    // short command and short response token length
    localparam int frameBits = 48;

    // width of the SD command line checksum
    localparam int crcBits = 7;

    // max cycles from the command end bit to the response start bit
    localparam int respWindow = 64;

    // result handed back to the host with ack
    typedef enum logic [1:0] {
        // response good, or none was expected
        stOk,
        // no start bit seen inside the window
        stTimeout,
        // nonzero remainder over the received token
        stCrcError,
        // bad transmission bit, bad end bit or index mismatch
        stFrameError
    } cmdStatus;

    // controller FSM
    typedef enum logic [2:0] {
        // waiting for req
        idle,
        // token going out on the line
        sending,
        // window timer running, looking for a start bit
        waiting,
        // response being shifted in
        receiving,
        // result latched, ack handshake in progress
        done
    } ctrlState;

endpackage

`default_nettype wire
